/* hw/eth_axi_pkg.sv */
package eth_axi_pkg;

   // AXI4 field widths
   localparam int axi_id_w    = 4;
   localparam int axi_len_w   = 8;
   localparam int axi_size_w  = 3;
   localparam int axi_burst_w = 2;
   localparam int axi_lock_w  = 1;
   localparam int axi_cache_w = 4;
   localparam int axi_prot_w  = 3;
   localparam int axi_qos_w   = 4;
   localparam int axi_resp_w  = 2;

   localparam int axi_addr_w  = 32;
   localparam int axi_data_w  = 32;
   localparam int axi_strb_w  = axi_data_w / 8;

   // fixed attributes, single 4-byte beats
   localparam logic [axi_size_w-1:0]  axi_size_word = 3'd2;
   localparam logic [axi_cache_w-1:0] axi_cache_val = 4'b0011;  // normal non-cacheable bufferable
   localparam logic [axi_prot_w-1:0]  axi_prot_val  = 3'b010;   // unprivileged non-secure data

endpackage

/* hw/eth_dma_pkg.sv */
package eth_dma_pkg;

   // packet buffer geometry
   localparam int buf_idx_w = 11;
   localparam int buf_depth = 2048;

   localparam int lane_w    = 2;   // byte lane inside a 32-bit word
   localparam int byte_w    = 8;

   // buffer arbiter clients
   localparam int arb_ports = 2;
   localparam int arb_rd    = 0;
   localparam int arb_wr    = 1;

endpackage

/* hw/eth_pkt_buf.sv */
`timescale 1ns/1ps

module eth_pkt_buf
   import eth_dma_pkg::*;
(
   input  logic                 clk,
   input  logic                 en,
   input  logic                 we,
   input  logic [buf_idx_w-1:0] idx,
   input  logic [byte_w-1:0]    wdata,
   output logic [byte_w-1:0]    rdata
);

   logic [byte_w-1:0] mem [buf_depth];

   // rdata only moves on a read
   always_ff @(posedge clk) begin
      if (en) begin
         if (we)
            mem[idx] <= wdata;
         else
            rdata <= mem[idx];
      end
   end

endmodule

/* hw/eth_buf_arb.sv */
`timescale 1ns/1ps

module eth_buf_arb
   import eth_dma_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,

   input  logic                 rd_req,
   input  logic [buf_idx_w-1:0] rd_idx,
   input  logic [byte_w-1:0]    rd_wdata,
   output logic                 rd_ack,

   input  logic                 wr_req,
   input  logic [buf_idx_w-1:0] wr_idx,
   output logic                 wr_ack,
   output logic [byte_w-1:0]    wr_rdata,

   output logic                 ram_en,
   output logic                 ram_we,
   output logic [buf_idx_w-1:0] ram_idx,
   output logic [byte_w-1:0]    ram_wdata,
   input  logic [byte_w-1:0]    ram_rdata
);

   localparam int sel_w = $clog2(arb_ports);

   logic [arb_ports-1:0] req_v;
   logic [arb_ports-1:0] ack_q;
   logic [sel_w-1:0]     last;    // client served most recently, owns the port while busy
   logic [sel_w-1:0]     pick;
   logic                 busy;

   assign req_v[arb_rd] = rd_req;
   assign req_v[arb_wr] = wr_req;

   assign busy = |ack_q;

   // the other client wins a tie
   assign pick = req_v[~last] ? ~last : last;

   assign ram_en    = !busy && |req_v;
   assign ram_we    = (pick == sel_w'(arb_rd));   // read engine only writes
   assign ram_idx   = (pick == sel_w'(arb_rd)) ? rd_idx : wr_idx;
   assign ram_wdata = rd_wdata;
   assign wr_rdata  = ram_rdata;

   assign rd_ack = ack_q[arb_rd];
   assign wr_ack = ack_q[arb_wr];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         last  <= sel_w'(arb_wr);
         ack_q <= '0;
      end else if (!busy) begin
         if (|req_v) begin
            last        <= pick;
            ack_q[pick] <= 1'b1;
         end
      end else if (!req_v[last]) begin
         ack_q[last] <= 1'b0;   // port free again once ack is down
      end
   end

endmodule

/* hw/eth_dma_rd.sv */
`timescale 1ns/1ps

module eth_dma_rd
   import eth_axi_pkg::*, eth_dma_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,

   output logic [axi_id_w-1:0]    m_axi_arid,
   output logic [axi_addr_w-1:0]  m_axi_araddr,
   output logic [axi_len_w-1:0]   m_axi_arlen,
   output logic [axi_size_w-1:0]  m_axi_arsize,
   output logic [axi_burst_w-1:0] m_axi_arburst,
   output logic [axi_lock_w-1:0]  m_axi_arlock,
   output logic [axi_cache_w-1:0] m_axi_arcache,
   output logic [axi_prot_w-1:0]  m_axi_arprot,
   output logic [axi_qos_w-1:0]   m_axi_arqos,
   output logic                   m_axi_arvalid,
   input  logic                   m_axi_arready,

   input  logic [axi_id_w-1:0]    m_axi_rid,
   input  logic [axi_data_w-1:0]  m_axi_rdata,
   input  logic [axi_resp_w-1:0]  m_axi_rresp,
   input  logic                   m_axi_rlast,
   input  logic                   m_axi_rvalid,
   output logic                   m_axi_rready,

   input  logic                   rd_req,
   input  logic [axi_addr_w-1:0]  rd_addr,
   input  logic [buf_idx_w-1:0]   rd_start,
   input  logic [buf_idx_w-1:0]   rd_end,
   output logic                   rd_ack,

   output logic                   buf_req,
   output logic                   buf_we,
   output logic [buf_idx_w-1:0]   buf_idx,
   output logic [byte_w-1:0]      buf_wdata,
   input  logic                   buf_ack
);

   typedef enum logic [2:0] {s_idle, s_ar, s_r, s_buf, s_rel, s_done} state_t;

   state_t                  state;
   logic [buf_idx_w-1:0]    idx;
   logic [buf_idx_w-1:0]    end_idx;
   logic [buf_idx_w-1:0]    idx_nxt;
   logic [axi_strb_w-1:0]   lane;      // one-hot
   logic [axi_data_w-1:0]   word;

   // single beat reads, rid/rresp/rlast not looked at
   assign m_axi_arid    = '0;
   assign m_axi_arlen   = '0;
   assign m_axi_arsize  = axi_size_word;
   assign m_axi_arburst = 2'b01;   // INCR
   assign m_axi_arlock  = '0;
   assign m_axi_arcache = axi_cache_val;
   assign m_axi_arprot  = axi_prot_val;
   assign m_axi_arqos   = '0;

   assign buf_we  = 1'b1;
   assign buf_idx = idx;
   assign idx_nxt = idx + 1'b1;

   // pick the byte of the stored word for the current lane
   always_comb begin
      buf_wdata = word[0 +: byte_w];
      for (int i = 1; i < axi_strb_w; i++) begin
         if (lane[i])
            buf_wdata = word[i*byte_w +: byte_w];
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state         <= s_idle;
         m_axi_arvalid <= 1'b0;
         m_axi_rready  <= 1'b0;
         m_axi_araddr  <= '0;
         buf_req       <= 1'b0;
         rd_ack        <= 1'b0;
         idx           <= '0;
         end_idx       <= '0;
         lane          <= '0;
         word          <= '0;
      end else begin
         case (state)
            s_idle: begin
               if (rd_req) begin
                  idx           <= rd_start;
                  end_idx       <= rd_end;
                  lane          <= axi_strb_w'(1) << rd_addr[lane_w-1:0];
                  m_axi_araddr  <= {rd_addr[axi_addr_w-1:lane_w], lane_w'(0)};
                  m_axi_arvalid <= 1'b1;
                  state         <= s_ar;
               end
            end
            s_ar: begin
               if (m_axi_arready) begin
                  m_axi_arvalid <= 1'b0;
                  m_axi_rready  <= 1'b1;
                  state         <= s_r;
               end
            end
            s_r: begin
               if (m_axi_rvalid) begin
                  m_axi_rready <= 1'b0;
                  word         <= m_axi_rdata;
                  buf_req      <= 1'b1;
                  state        <= s_buf;
               end
            end
            s_buf: begin
               if (buf_ack) begin
                  buf_req <= 1'b0;
                  state   <= s_rel;
               end
            end
            s_rel: begin
               // wait for the arbiter to drop ack before the next byte
               if (!buf_ack) begin
                  idx  <= idx_nxt;
                  lane <= {lane[axi_strb_w-2:0], lane[axi_strb_w-1]};
                  if (idx_nxt == end_idx) begin
                     rd_ack <= 1'b1;
                     state  <= s_done;
                  end else if (lane[axi_strb_w-1]) begin
                     m_axi_araddr  <= m_axi_araddr + axi_addr_w'(axi_strb_w);
                     m_axi_arvalid <= 1'b1;
                     state         <= s_ar;
                  end else begin
                     buf_req <= 1'b1;
                     state   <= s_buf;
                  end
               end
            end
            s_done: begin
               if (!rd_req) begin
                  rd_ack <= 1'b0;
                  state  <= s_idle;
               end
            end
            default: state <= s_idle;
         endcase
      end
   end

endmodule

/* hw/eth_dma_wr.sv */
`timescale 1ns/1ps

module eth_dma_wr
   import eth_axi_pkg::*, eth_dma_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,

   output logic [axi_id_w-1:0]    m_axi_awid,
   output logic [axi_addr_w-1:0]  m_axi_awaddr,
   output logic [axi_len_w-1:0]   m_axi_awlen,
   output logic [axi_size_w-1:0]  m_axi_awsize,
   output logic [axi_burst_w-1:0] m_axi_awburst,
   output logic [axi_lock_w-1:0]  m_axi_awlock,
   output logic [axi_cache_w-1:0] m_axi_awcache,
   output logic [axi_prot_w-1:0]  m_axi_awprot,
   output logic [axi_qos_w-1:0]   m_axi_awqos,
   output logic                   m_axi_awvalid,
   input  logic                   m_axi_awready,

   output logic [axi_data_w-1:0]  m_axi_wdata,
   output logic [axi_strb_w-1:0]  m_axi_wstrb,
   output logic                   m_axi_wlast,
   output logic                   m_axi_wvalid,
   input  logic                   m_axi_wready,

   input  logic [axi_id_w-1:0]    m_axi_bid,
   input  logic [axi_resp_w-1:0]  m_axi_bresp,
   input  logic                   m_axi_bvalid,
   output logic                   m_axi_bready,

   input  logic                   wr_req,
   input  logic [axi_addr_w-1:0]  wr_addr,
   input  logic [buf_idx_w-1:0]   wr_start,
   input  logic [buf_idx_w-1:0]   wr_end,
   output logic                   wr_ack,

   output logic                   buf_req,
   output logic [buf_idx_w-1:0]   buf_idx,
   input  logic                   buf_ack,
   input  logic [byte_w-1:0]      buf_rdata
);

   typedef enum logic [2:0] {s_idle, s_rd, s_rel, s_axi, s_resp, s_done} state_t;

   state_t                  state;
   logic [buf_idx_w-1:0]    idx;
   logic [buf_idx_w-1:0]    end_idx;
   logic [buf_idx_w-1:0]    idx_nxt;
   logic [lane_w-1:0]       lane;
   logic [axi_data_w-1:0]   word;
   logic [axi_strb_w-1:0]   strb;
   logic                    aw_done;
   logic                    w_done;

   assign m_axi_awid    = '0;
   assign m_axi_awlen   = '0;
   assign m_axi_awsize  = axi_size_word;
   assign m_axi_awburst = 2'b01;
   assign m_axi_awlock  = '0;
   assign m_axi_awcache = axi_cache_val;
   assign m_axi_awprot  = axi_prot_val;
   assign m_axi_awqos   = '0;

   assign m_axi_wdata = word;
   assign m_axi_wstrb = strb;
   assign m_axi_wlast = 1'b1;   // every beat is a whole burst

   assign buf_idx = idx;
   assign idx_nxt = idx + 1'b1;

   // channel finished or finishing on this edge
   assign aw_done = !m_axi_awvalid || m_axi_awready;
   assign w_done  = !m_axi_wvalid || m_axi_wready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state         <= s_idle;
         m_axi_awvalid <= 1'b0;
         m_axi_wvalid  <= 1'b0;
         m_axi_bready  <= 1'b0;
         m_axi_awaddr  <= '0;
         buf_req       <= 1'b0;
         wr_ack        <= 1'b0;
         idx           <= '0;
         end_idx       <= '0;
         lane          <= '0;
         word          <= '0;
         strb          <= '0;
      end else begin
         case (state)
            s_idle: begin
               if (wr_req) begin
                  idx          <= wr_start;
                  end_idx      <= wr_end;
                  lane         <= wr_addr[lane_w-1:0];
                  strb         <= '0;
                  m_axi_awaddr <= {wr_addr[axi_addr_w-1:lane_w], lane_w'(0)};
                  buf_req      <= 1'b1;
                  state        <= s_rd;
               end
            end
            s_rd: begin
               if (buf_ack) begin
                  word[lane*byte_w +: byte_w] <= buf_rdata;
                  strb[lane]                  <= 1'b1;
                  buf_req                     <= 1'b0;
                  state                       <= s_rel;
               end
            end
            s_rel: begin
               if (!buf_ack) begin
                  idx <= idx_nxt;
                  if (&lane || idx_nxt == end_idx) begin
                     m_axi_awvalid <= 1'b1;
                     m_axi_wvalid  <= 1'b1;
                     state         <= s_axi;
                  end else begin
                     lane    <= lane + 1'b1;
                     buf_req <= 1'b1;
                     state   <= s_rd;
                  end
               end
            end
            s_axi: begin
               if (m_axi_awready)
                  m_axi_awvalid <= 1'b0;
               if (m_axi_wready)
                  m_axi_wvalid <= 1'b0;
               if (aw_done && w_done) begin
                  m_axi_bready <= 1'b1;
                  state        <= s_resp;
               end
            end
            s_resp: begin
               if (m_axi_bvalid) begin   // bresp ignored
                  m_axi_bready <= 1'b0;
                  if (idx == end_idx) begin
                     wr_ack <= 1'b1;
                     state  <= s_done;
                  end else begin
                     m_axi_awaddr <= m_axi_awaddr + axi_addr_w'(axi_strb_w);
                     lane         <= '0;
                     strb         <= '0;
                     buf_req      <= 1'b1;
                     state        <= s_rd;
                  end
               end
            end
            s_done: begin
               if (!wr_req) begin
                  wr_ack <= 1'b0;
                  state  <= s_idle;
               end
            end
            default: state <= s_idle;
         endcase
      end
   end

endmodule

/* hw/eth_dma.sv */
`timescale 1ns/1ps

module eth_dma
   import eth_axi_pkg::*, eth_dma_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,

   output logic [axi_id_w-1:0]    m_axi_arid,
   output logic [axi_addr_w-1:0]  m_axi_araddr,
   output logic [axi_len_w-1:0]   m_axi_arlen,
   output logic [axi_size_w-1:0]  m_axi_arsize,
   output logic [axi_burst_w-1:0] m_axi_arburst,
   output logic [axi_lock_w-1:0]  m_axi_arlock,
   output logic [axi_cache_w-1:0] m_axi_arcache,
   output logic [axi_prot_w-1:0]  m_axi_arprot,
   output logic [axi_qos_w-1:0]   m_axi_arqos,
   output logic                   m_axi_arvalid,
   input  logic                   m_axi_arready,

   input  logic [axi_id_w-1:0]    m_axi_rid,
   input  logic [axi_data_w-1:0]  m_axi_rdata,
   input  logic [axi_resp_w-1:0]  m_axi_rresp,
   input  logic                   m_axi_rlast,
   input  logic                   m_axi_rvalid,
   output logic                   m_axi_rready,

   output logic [axi_id_w-1:0]    m_axi_awid,
   output logic [axi_addr_w-1:0]  m_axi_awaddr,
   output logic [axi_len_w-1:0]   m_axi_awlen,
   output logic [axi_size_w-1:0]  m_axi_awsize,
   output logic [axi_burst_w-1:0] m_axi_awburst,
   output logic [axi_lock_w-1:0]  m_axi_awlock,
   output logic [axi_cache_w-1:0] m_axi_awcache,
   output logic [axi_prot_w-1:0]  m_axi_awprot,
   output logic [axi_qos_w-1:0]   m_axi_awqos,
   output logic                   m_axi_awvalid,
   input  logic                   m_axi_awready,

   output logic [axi_data_w-1:0]  m_axi_wdata,
   output logic [axi_strb_w-1:0]  m_axi_wstrb,
   output logic                   m_axi_wlast,
   output logic                   m_axi_wvalid,
   input  logic                   m_axi_wready,

   input  logic [axi_id_w-1:0]    m_axi_bid,
   input  logic [axi_resp_w-1:0]  m_axi_bresp,
   input  logic                   m_axi_bvalid,
   output logic                   m_axi_bready,

   input  logic                   rd_req,
   input  logic [axi_addr_w-1:0]  rd_addr,
   input  logic [buf_idx_w-1:0]   rd_start,
   input  logic [buf_idx_w-1:0]   rd_end,
   output logic                   rd_ack,

   input  logic                   wr_req,
   input  logic [axi_addr_w-1:0]  wr_addr,
   input  logic [buf_idx_w-1:0]   wr_start,
   input  logic [buf_idx_w-1:0]   wr_end,
   output logic                   wr_ack
);

   // buf0 is the read engine, buf1 the write engine
   logic                 buf0_req;
   logic [buf_idx_w-1:0] buf0_idx;
   logic [byte_w-1:0]    buf0_wdata;
   logic                 buf0_ack;
   logic                 buf1_req;
   logic [buf_idx_w-1:0] buf1_idx;
   logic                 buf1_ack;
   logic [byte_w-1:0]    buf1_rdata;

   logic                 ram_en;
   logic                 ram_we;
   logic [buf_idx_w-1:0] ram_idx;
   logic [byte_w-1:0]    ram_wdata;
   logic [byte_w-1:0]    ram_rdata;

   eth_dma_rd u_rd (
      .buf_req   (buf0_req),
      .buf_we    (),          // write direction is implied by the arbiter port
      .buf_idx   (buf0_idx),
      .buf_wdata (buf0_wdata),
      .buf_ack   (buf0_ack),
      .*
   );

   eth_dma_wr u_wr (
      .buf_req   (buf1_req),
      .buf_idx   (buf1_idx),
      .buf_ack   (buf1_ack),
      .buf_rdata (buf1_rdata),
      .*
   );

   eth_buf_arb u_arb (
      .clk       (clk),
      .rst       (rst),
      .rd_req    (buf0_req),
      .rd_idx    (buf0_idx),
      .rd_wdata  (buf0_wdata),
      .rd_ack    (buf0_ack),
      .wr_req    (buf1_req),
      .wr_idx    (buf1_idx),
      .wr_ack    (buf1_ack),
      .wr_rdata  (buf1_rdata),
      .ram_en    (ram_en),
      .ram_we    (ram_we),
      .ram_idx   (ram_idx),
      .ram_wdata (ram_wdata),
      .ram_rdata (ram_rdata)
   );

   eth_pkt_buf u_buf (
      .clk   (clk),
      .en    (ram_en),
      .we    (ram_we),
      .idx   (ram_idx),
      .wdata (ram_wdata),
      .rdata (ram_rdata)
   );

endmodule

/* verification/eth_dma_clk.sv */
`timescale 1ns/1ps

module eth_dma_clk (
   output logic clk,
   output logic rst
);

   localparam int half_period = 10;   // 20 ns clock
   localparam int rst_cycles  = 10;

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      repeat (rst_cycles) @(posedge clk);
      rst <= 1'b0;
   end

   always #half_period clk = ~clk;

endmodule

/* verification/eth_axi_mem.sv */
`timescale 1ns/1ps

module eth_axi_mem
   import eth_axi_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,

   input  logic [axi_addr_w-1:0] m_axi_araddr,
   input  logic                  m_axi_arvalid,
   output logic                  m_axi_arready = 1'b0,
   output logic [axi_id_w-1:0]   m_axi_rid,
   output logic [axi_data_w-1:0] m_axi_rdata = '0,
   output logic [axi_resp_w-1:0] m_axi_rresp,
   output logic                  m_axi_rlast,
   output logic                  m_axi_rvalid = 1'b0,
   input  logic                  m_axi_rready,

   input  logic [axi_addr_w-1:0] m_axi_awaddr,
   input  logic                  m_axi_awvalid,
   output logic                  m_axi_awready = 1'b0,
   input  logic [axi_data_w-1:0] m_axi_wdata,
   input  logic [axi_strb_w-1:0] m_axi_wstrb,
   input  logic                  m_axi_wvalid,
   output logic                  m_axi_wready = 1'b0,
   output logic [axi_id_w-1:0]   m_axi_bid,
   output logic [axi_resp_w-1:0] m_axi_bresp,
   output logic                  m_axi_bvalid = 1'b0,
   input  logic                  m_axi_bready
);

   localparam int mem_words = 256;   // 1 KiB, upper address bits ignored

   logic [axi_data_w-1:0] mem [mem_words];
   logic [31:0]           rnd;
   logic [7:0]            aw_word;
   logic [axi_data_w-1:0] w_data;
   logic [axi_strb_w-1:0] w_strb;
   logic                  r_pend;
   logic                  aw_got;
   logic                  w_got;

   assign m_axi_rid   = '0;
   assign m_axi_rresp = '0;
   assign m_axi_rlast = 1'b1;
   assign m_axi_bid   = '0;
   assign m_axi_bresp = '0;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // each byte depends on its full 10-bit address
   initial begin
      for (int a = 0; a < mem_words * 4; a++)
         mem[a / 4][(a % 4) * 8 +: 8] = 8'((a * 7) ^ (a >> 5));
   end

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         rnd           <= 32'hf99b;
         m_axi_arready <= 1'b0;
         m_axi_rvalid  <= 1'b0;
         m_axi_awready <= 1'b0;
         m_axi_wready  <= 1'b0;
         m_axi_bvalid  <= 1'b0;
         r_pend        <= 1'b0;
         aw_got        <= 1'b0;
         w_got         <= 1'b0;
      end else begin
         rnd <= lcg_next(rnd);

         m_axi_arready <= rnd[31] && !r_pend && !m_axi_rvalid
                          && !(m_axi_arvalid && m_axi_arready);
         if (m_axi_arvalid && m_axi_arready) begin
            m_axi_rdata <= mem[m_axi_araddr[2 +: 8]];
            r_pend      <= 1'b1;
         end
         if (r_pend && rnd[30]) begin   // random gap before rvalid
            m_axi_rvalid <= 1'b1;
            r_pend       <= 1'b0;
         end
         if (m_axi_rvalid && m_axi_rready)
            m_axi_rvalid <= 1'b0;

         m_axi_awready <= rnd[29] && !aw_got && !(m_axi_awvalid && m_axi_awready);
         m_axi_wready  <= rnd[28] && !w_got && !(m_axi_wvalid && m_axi_wready);
         if (m_axi_awvalid && m_axi_awready) begin
            aw_word <= m_axi_awaddr[2 +: 8];
            aw_got  <= 1'b1;
         end
         if (m_axi_wvalid && m_axi_wready) begin
            w_data <= m_axi_wdata;
            w_strb <= m_axi_wstrb;
            w_got  <= 1'b1;
         end
         // commit the strobed bytes together with bvalid
         if (aw_got && w_got && !m_axi_bvalid && rnd[27]) begin
            for (int i = 0; i < axi_strb_w; i++) begin
               if (w_strb[i])
                  mem[aw_word][i*8 +: 8] <= w_data[i*8 +: 8];
            end
            aw_got       <= 1'b0;
            w_got        <= 1'b0;
            m_axi_bvalid <= 1'b1;
         end
         if (m_axi_bvalid && m_axi_bready)
            m_axi_bvalid <= 1'b0;
      end
   end

endmodule

/* verification/eth_dma_tb.sv */
`timescale 1ns/1ps

module eth_dma_tb
   import eth_axi_pkg::*, eth_dma_pkg::*;
();

   localparam int mem_bytes  = 1024;
   localparam int wait_limit = 4000;   // cycles per wait loop

   logic                   clk;
   logic                   rst;

   logic [axi_id_w-1:0]    m_axi_arid;
   logic [axi_addr_w-1:0]  m_axi_araddr;
   logic [axi_len_w-1:0]   m_axi_arlen;
   logic [axi_size_w-1:0]  m_axi_arsize;
   logic [axi_burst_w-1:0] m_axi_arburst;
   logic [axi_lock_w-1:0]  m_axi_arlock;
   logic [axi_cache_w-1:0] m_axi_arcache;
   logic [axi_prot_w-1:0]  m_axi_arprot;
   logic [axi_qos_w-1:0]   m_axi_arqos;
   logic                   m_axi_arvalid;
   logic                   m_axi_arready;
   logic [axi_id_w-1:0]    m_axi_rid;
   logic [axi_data_w-1:0]  m_axi_rdata;
   logic [axi_resp_w-1:0]  m_axi_rresp;
   logic                   m_axi_rlast;
   logic                   m_axi_rvalid;
   logic                   m_axi_rready;

   logic [axi_id_w-1:0]    m_axi_awid;
   logic [axi_addr_w-1:0]  m_axi_awaddr;
   logic [axi_len_w-1:0]   m_axi_awlen;
   logic [axi_size_w-1:0]  m_axi_awsize;
   logic [axi_burst_w-1:0] m_axi_awburst;
   logic [axi_lock_w-1:0]  m_axi_awlock;
   logic [axi_cache_w-1:0] m_axi_awcache;
   logic [axi_prot_w-1:0]  m_axi_awprot;
   logic [axi_qos_w-1:0]   m_axi_awqos;
   logic                   m_axi_awvalid;
   logic                   m_axi_awready;
   logic [axi_data_w-1:0]  m_axi_wdata;
   logic [axi_strb_w-1:0]  m_axi_wstrb;
   logic                   m_axi_wlast;
   logic                   m_axi_wvalid;
   logic                   m_axi_wready;
   logic [axi_id_w-1:0]    m_axi_bid;
   logic [axi_resp_w-1:0]  m_axi_bresp;
   logic                   m_axi_bvalid;
   logic                   m_axi_bready;

   logic                   rd_req;
   logic [axi_addr_w-1:0]  rd_addr;
   logic [buf_idx_w-1:0]   rd_start;
   logic [buf_idx_w-1:0]   rd_end;
   logic                   rd_ack;
   logic                   wr_req;
   logic [axi_addr_w-1:0]  wr_addr;
   logic [buf_idx_w-1:0]   wr_start;
   logic [buf_idx_w-1:0]   wr_end;
   logic                   wr_ack;

   // reference copies of system memory and packet buffer
   logic [byte_w-1:0]      exp_mem [mem_bytes];
   logic [byte_w-1:0]      exp_buf [buf_depth];

   // last sampled values for the protocol monitor
   logic                   ar_hold;
   logic                   aw_hold;
   logic                   w_hold;
   logic [axi_addr_w-1:0]  araddr_q;
   logic [axi_addr_w-1:0]  awaddr_q;
   logic [axi_data_w-1:0]  wdata_q;
   logic [axi_strb_w-1:0]  wstrb_q;
   logic                   rd_req_q;
   logic                   rd_ack_q;
   logic                   wr_req_q;
   logic                   wr_ack_q;

   eth_dma_clk u_clk (.clk(clk), .rst(rst));
   eth_dma     DUT (.*);
   eth_axi_mem u_mem (.*);

   task automatic fail_run(input string why);
      $display("Verification failed");
      $fatal(1, "%s", why);
   endtask

   task automatic report_mismatch(input string what);
      $display("error at %0t ns: %s", $time, what);
      fail_run("a checked value was wrong");
   endtask

   function automatic logic [byte_w-1:0] mem_byte(input int a);
      return u_mem.mem[a / 4][(a % 4) * byte_w +: byte_w];
   endfunction

   task automatic load_reference();
      for (int a = 0; a < mem_bytes; a++)
         exp_mem[a] = mem_byte(a);
   endtask

   task automatic check_memory(input string phase);
      for (int a = 0; a < mem_bytes; a++) begin
         assert (mem_byte(a) === exp_mem[a])
         else report_mismatch($sformatf("%s: mem[%03h] is %02h, expected %02h",
                                        phase, a, mem_byte(a), exp_mem[a]));
      end
   endtask

   task automatic check_idle_outputs();
      assert ({rd_ack, wr_ack, m_axi_arvalid, m_axi_rready, m_axi_awvalid, m_axi_wvalid,
               m_axi_bready, DUT.buf0_ack, DUT.buf1_ack} === 9'b0)
      else report_mismatch("control output not low while idle after reset");
   endtask

   task automatic do_read(input logic [axi_addr_w-1:0] addr, input int first_idx,
                          input int end_idx);
      int n;
      @(posedge clk);
      rd_addr  <= addr;
      rd_start <= first_idx[buf_idx_w-1:0];
      rd_end   <= end_idx[buf_idx_w-1:0];
      rd_req   <= 1'b1;
      n = 0;
      while (!rd_ack && n < wait_limit) begin
         @(posedge clk);
         n++;
      end
      if (!rd_ack)
         fail_run("read engine never acknowledged its command");
      rd_req <= 1'b0;
      n = 0;
      while (rd_ack && n < wait_limit) begin
         @(posedge clk);
         n++;
      end
      if (rd_ack)
         fail_run("read engine kept rd_ack high after rd_req fell");
      for (int i = first_idx; i < end_idx; i++)
         exp_buf[i] = exp_mem[(addr + i - first_idx) % mem_bytes];
   endtask

   task automatic do_write(input logic [axi_addr_w-1:0] addr, input int first_idx,
                           input int end_idx);
      int n;
      @(posedge clk);
      wr_addr  <= addr;
      wr_start <= first_idx[buf_idx_w-1:0];
      wr_end   <= end_idx[buf_idx_w-1:0];
      wr_req   <= 1'b1;
      n = 0;
      while (!wr_ack && n < wait_limit) begin
         @(posedge clk);
         n++;
      end
      if (!wr_ack)
         fail_run("write engine never acknowledged its command");
      wr_req <= 1'b0;
      n = 0;
      while (wr_ack && n < wait_limit) begin
         @(posedge clk);
         n++;
      end
      if (wr_ack)
         fail_run("write engine kept wr_ack high after wr_req fell");
      for (int i = first_idx; i < end_idx; i++)
         exp_mem[(addr + i - first_idx) % mem_bytes] = exp_buf[i];
   endtask

   // AXI stability, four-phase order, single buffer grant
   always @(posedge clk) begin
      if (rst) begin
         ar_hold  <= 1'b0;
         aw_hold  <= 1'b0;
         w_hold   <= 1'b0;
         rd_req_q <= 1'b0;
         rd_ack_q <= 1'b0;
         wr_req_q <= 1'b0;
         wr_ack_q <= 1'b0;
      end else begin
         if (ar_hold)
            assert (m_axi_arvalid && m_axi_araddr == araddr_q)
            else report_mismatch("AR request changed before arready");
         if (aw_hold)
            assert (m_axi_awvalid && m_axi_awaddr == awaddr_q)
            else report_mismatch("AW request changed before awready");
         if (w_hold)
            assert (m_axi_wvalid && m_axi_wdata == wdata_q && m_axi_wstrb == wstrb_q)
            else report_mismatch("W beat changed before wready");

         // single 4-byte INCR beat, normal non-cacheable bufferable, unprivileged data
         if (m_axi_arvalid)
            assert ({m_axi_arid, m_axi_arlen, m_axi_arsize, m_axi_arburst, m_axi_arlock,
                     m_axi_arcache, m_axi_arprot, m_axi_arqos}
                    === {4'd0, 8'd0, 3'd2, 2'b01, 1'b0, 4'b0011, 3'b010, 4'd0})
            else report_mismatch("AR attributes wrong for a single 4-byte beat");
         if (m_axi_awvalid)
            assert ({m_axi_awid, m_axi_awlen, m_axi_awsize, m_axi_awburst, m_axi_awlock,
                     m_axi_awcache, m_axi_awprot, m_axi_awqos}
                    === {4'd0, 8'd0, 3'd2, 2'b01, 1'b0, 4'b0011, 3'b010, 4'd0})
            else report_mismatch("AW attributes wrong for a single 4-byte beat");
         if (m_axi_wvalid)
            assert (m_axi_wlast === 1'b1)
            else report_mismatch("wlast low on a single-beat write");

         assert (!(rd_ack && !rd_ack_q) || rd_req_q)
         else report_mismatch("rd_ack rose without rd_req");
         assert (!(!rd_ack && rd_ack_q) || !rd_req_q)
         else report_mismatch("rd_ack fell while rd_req was high");
         assert (!(rd_ack_q && !rd_req_q) || !rd_ack)
         else report_mismatch("rd_ack stayed high after rd_req fell");
         assert (!(wr_ack && !wr_ack_q) || wr_req_q)
         else report_mismatch("wr_ack rose without wr_req");
         assert (!(!wr_ack && wr_ack_q) || !wr_req_q)
         else report_mismatch("wr_ack fell while wr_req was high");
         assert (!(wr_ack_q && !wr_req_q) || !wr_ack)
         else report_mismatch("wr_ack stayed high after wr_req fell");
         assert (!(DUT.buf0_ack && DUT.buf1_ack))
         else report_mismatch("both buffer clients granted at once");

         ar_hold  <= m_axi_arvalid && !m_axi_arready;
         aw_hold  <= m_axi_awvalid && !m_axi_awready;
         w_hold   <= m_axi_wvalid && !m_axi_wready;
         araddr_q <= m_axi_araddr;
         awaddr_q <= m_axi_awaddr;
         wdata_q  <= m_axi_wdata;
         wstrb_q  <= m_axi_wstrb;
         rd_req_q <= rd_req;
         rd_ack_q <= rd_ack;
         wr_req_q <= wr_req;
         wr_ack_q <= wr_ack;
      end
   end

   initial begin
      int n;
      rd_req   = 1'b0;
      rd_addr  = '0;
      rd_start = '0;
      rd_end   = '0;
      wr_req   = 1'b0;
      wr_addr  = '0;
      wr_start = '0;
      wr_end   = '0;

      n = 0;
      while (rst !== 1'b0 && n < 100) begin
         @(posedge clk);
         n++;
      end
      if (rst !== 1'b0)
         fail_run("reset was never released");
      check_idle_outputs();
      repeat (5) @(posedge clk);   // no command yet, acks stay low
      check_idle_outputs();
      load_reference();

      do_read(32'h040, 0, 32);
      do_write(32'h200, 0, 32);
      check_memory("aligned");

      // source lane 1, destination lane 2, odd length
      do_read(32'h081, 100, 119);
      do_write(32'h302, 100, 119);
      check_memory("unaligned");

      fork
         do_read(32'h10e, 500, 537);
         do_write(32'h3a3, 0, 32);
      join
      do_write(32'h1d6, 500, 537);   // bring the concurrent read out to memory
      check_memory("concurrent");

      $display("Verification passed");
      $finish;
   end

endmodule

/* eth_dma.f */
hw/eth_axi_pkg.sv
hw/eth_dma_pkg.sv
hw/eth_pkt_buf.sv
hw/eth_buf_arb.sv
hw/eth_dma_rd.sv
hw/eth_dma_wr.sv
hw/eth_dma.sv
verification/eth_dma_clk.sv
verification/eth_axi_mem.sv
verification/eth_dma_tb.sv

/* Bender.yml */
package:
  name: eth_dma

sources:
  - hw/eth_axi_pkg.sv
  - hw/eth_dma_pkg.sv
  - hw/eth_pkt_buf.sv
  - hw/eth_buf_arb.sv
  - hw/eth_dma_rd.sv
  - hw/eth_dma_wr.sv
  - hw/eth_dma.sv
  - target: simulation
    files:
      - verification/eth_dma_clk.sv
      - verification/eth_axi_mem.sv
      - verification/eth_dma_tb.sv
